// ==== ppu.f ====
+incdir+tests
common/ppu_pkg.sv
common/ppu_if.sv
design/vram/video_memory.sv
design/render/background_renderer.sv
design/render/sprite_renderer.sv
design/scanout.sv
design/ppu_top.sv
tests/tb_ppu.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_ppu
RTL_TOP    := ppu_top
FILELIST   := ppu.f
COMMON     := --timescale 1ns/1ps --timing
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(COMMON) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(COMMON) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/ppu_model.svh ====
`ifndef PPU_MODEL_SVH
`define PPU_MODEL_SVH

// ============================================================================
// Mirror of video memory, filled alongside every host write
// ============================================================================
color12_t   m_pal  [PAL_ENTRIES];
logic [7:0] m_tile [TILE_MEM_BYTES];
logic [7:0] m_map  [MAP_ENTRIES];
oam_attr_t  m_oam  [NUM_SPRITES];

int coord_errors = 0;
int color_errors = 0;
int other_errors = 0;

function automatic void mirror_write(input host_sel_t sel, input int addr,
                                     input logic [31:0] data);
    case (sel)
        SEL_PALETTE: m_pal[addr] = data[11:0];
        SEL_TILE:    m_tile[addr] = data[7:0];
        SEL_MAP:     m_map[addr] = data[7:0];
        default:     m_oam[addr] = data;                 // Whole attribute word
    endcase
endfunction

// 0x0 -> 0x00, 0xF -> 0xFF
function automatic channel_t scale4(input logic [3:0] n);
    return channel_t'(int'(n) * 17);
endfunction

// Tile pixel lookup with the left pixel of each byte in the upper nibble
function automatic logic [3:0] tile_nibble(input int tile, input int col, input int row);
    logic [7:0] b;
    b = m_tile[tile * TILE_BYTES + row * 4 + col / 2];
    return (col % 2 == 0) ? b[7:4] : b[3:0];
endfunction

// Expected colour at screen position (x, y)
function automatic void model_pixel(input int x, input int y, output channel_t r,
                                    output channel_t g, output channel_t b,
                                    output bit from_sprite);
    logic [3:0] nib;
    int         win_nib;
    int         win_pal;
    int         col;
    int         row;
    int         left;
    int         top;
    color12_t   c;
    from_sprite = 1'b0;
    win_nib     = 0;
    win_pal     = 0;
    for (int s = 0; s < NUM_SPRITES; s++) begin          // Higher number checked last wins
        left = int'(m_oam[s].x);
        top  = int'(m_oam[s].y);
        if (m_oam[s].enable && x >= left && x < left + TILE_DIM
            && y >= top && y < top + TILE_DIM) begin
            col = m_oam[s].hflip ? TILE_DIM - 1 - (x - left) : x - left;
            row = m_oam[s].vflip ? TILE_DIM - 1 - (y - top) : y - top;
            nib = tile_nibble(int'(m_oam[s].tile), col, row);
            if (nib != 4'hF) begin
                from_sprite = 1'b1;
                win_pal     = int'(m_oam[s].palette);
                win_nib     = int'(nib);
            end
        end
    end
    if (from_sprite) begin
        c = m_pal[win_pal * PALETTE_SIZE + win_nib];
    end else begin
        nib = tile_nibble(int'(m_map[(y / TILE_DIM) * MAP_DIM + x / TILE_DIM]),
                          x % TILE_DIM, y % TILE_DIM);
        c   = m_pal[int'(nib)];                          // Palette 0 only
    end
    if (!from_sprite && nib == 4'h0) begin
        r = 8'h88;                                       // Sky
        g = 8'hDD;
        b = 8'hFF;
    end else begin
        r = scale4(c[11:8]);
        g = scale4(c[7:4]);
        b = scale4(c[3:0]);
    end
endfunction

task automatic check_channel(input string name, input channel_t got, input channel_t exp,
                             input int x, input int y);
    if (got !== exp) begin
        color_errors++;
        $display("[ERROR] %s = %h, expected %h at x=%0d y=%0d", name, got, exp, x, y);
    end
endtask

task automatic check_coord(input xcoord_t got_x, input ycoord_t got_y,
                           input xcoord_t exp_x, input ycoord_t exp_y);
    if (got_x !== exp_x) begin
        coord_errors++;
        $display("[ERROR] pixel_x = %h, expected %h", got_x, exp_x);
    end
    if (got_y !== exp_y) begin
        coord_errors++;
        $display("[ERROR] pixel_y = %h, expected %h", got_y, exp_y);
    end
endtask

task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
        other_errors++;
        $display("[ERROR] pixel_valid = %h, expected %h", got, exp);
    end
endtask

`endif

// ==== tests/tb_ppu.sv ====
`timescale 1ns/1ps

module tb_ppu import ppu_pkg::*; ();

    logic        clk = 1'b0;
    logic        reset;
    logic        host_we;
    host_sel_t   host_sel;
    tile_addr_t  host_addr;
    logic [31:0] host_wdata;
    logic        pixel_valid;
    xcoord_t     pixel_x;
    ycoord_t     pixel_y;
    channel_t    pixel_r;
    channel_t    pixel_g;
    channel_t    pixel_b;

    integer seed = 61793;

    `include "ppu_model.svh"

    always #50 clk = ~clk;                               // 100 ns period

    ppu_top DUT (
        .clk         (clk),
        .reset       (reset),
        .host_we     (host_we),
        .host_sel    (host_sel),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_r     (pixel_r),
        .pixel_g     (pixel_g),
        .pixel_b     (pixel_b)
    );

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // ========================================================================
    // Host port driving
    // ========================================================================
    task automatic host_write(input host_sel_t sel, input int addr, input logic [31:0] data);
        @(negedge clk);
        check_valid(pixel_valid, 1'b1);                  // Scan keeps running during loads
        host_we    = 1'b1;
        host_sel   = sel;
        host_addr  = tile_addr_t'(addr);
        host_wdata = data;
        mirror_write(sel, addr, data);
    endtask

    task automatic host_idle();
        @(negedge clk);
        check_valid(pixel_valid, 1'b1);
        host_we    = 1'b0;
        host_wdata = '0;
    endtask

    task automatic load_memory();
        oam_attr_t a;
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            host_write(SEL_PALETTE, i, 32'(rand_below(4096)));
        end
        for (int i = 0; i < 32 * TILE_BYTES; i++) begin  // Tiles 0..31
            host_write(SEL_TILE, i, 32'(rand_below(256)));
        end
        for (int row = 0; row < DISP_HEIGHT / TILE_DIM; row++) begin
            for (int col = 0; col < DISP_WIDTH / TILE_DIM; col++) begin
                host_write(SEL_MAP, row * MAP_DIM + col, 32'(rand_below(32)));
            end
        end
        for (int s = 0; s < NUM_SPRITES; s++) begin
            a         = '0;
            a.enable  = (s == NUM_SPRITES - 1) || (rand_below(6) != 0);
            a.vflip   = 1'(rand_below(2));
            a.hflip   = 1'(rand_below(2));
            a.palette = 3'(rand_below(NUM_PALETTES));
            a.tile    = 9'(rand_below(32));
            if (s >= 3) begin                            // Clustered so they overlap
                a.x = xcoord_t'(100 + rand_below(6));
                a.y = ycoord_t'(60 + rand_below(6));
            end else begin
                a.x = xcoord_t'(rand_below(DISP_WIDTH - TILE_DIM + 1));
                a.y = ycoord_t'(rand_below(DISP_HEIGHT - TILE_DIM + 1));
            end
            host_write(SEL_OAM, s, a);
        end
        host_idle();
    endtask

    // Top sprite off, one map entry moved to a neighbouring tile
    task automatic change_scene();
        oam_attr_t  a;
        logic [7:0] old_tile;
        a        = m_oam[NUM_SPRITES - 1];
        a.enable = 1'b0;
        host_write(SEL_OAM, NUM_SPRITES - 1, a);
        old_tile = m_map[3 * MAP_DIM + 5];
        host_write(SEL_MAP, 3 * MAP_DIM + 5, {24'h0, old_tile ^ 8'h01});
        host_idle();
    endtask

    // ========================================================================
    // Output checking
    // ========================================================================
    task automatic check_reset_state();
        check_valid(pixel_valid, 1'b0);
        check_coord(pixel_x, pixel_y, '0, '0);
        check_channel("pixel_r", pixel_r, 8'h00, 0, 0);
        check_channel("pixel_g", pixel_g, 8'h00, 0, 0);
        check_channel("pixel_b", pixel_b, 8'h00, 0, 0);
    endtask

    task automatic wait_frame_start(output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < 100000) begin
            @(negedge clk);
            cycles++;
            if (pixel_valid !== 1'b1) begin
                check_valid(pixel_valid, 1'b1);
            end else if (pixel_x == '0 && pixel_y == '0) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            other_errors++;
            $display("No pixel at (0,0) appeared within %0d cycles", cycles);
        end
    endtask

    // Entered on the (0,0) pixel, left on the (0,0) pixel of the next frame
    task automatic check_frame(input string tag);
        int       ex;
        int       ey;
        int       spr_count;
        channel_t er;
        channel_t eg;
        channel_t eb;
        bit       spr;
        ex        = 0;
        ey        = 0;
        spr_count = 0;
        for (int i = 0; i <= DISP_WIDTH * DISP_HEIGHT; i++) begin
            if (i != 0) begin
                @(negedge clk);
            end
            check_valid(pixel_valid, 1'b1);
            check_coord(pixel_x, pixel_y, xcoord_t'(ex), ycoord_t'(ey));
            model_pixel(ex, ey, er, eg, eb, spr);
            check_channel("pixel_r", pixel_r, er, ex, ey);
            check_channel("pixel_g", pixel_g, eg, ex, ey);
            check_channel("pixel_b", pixel_b, eb, ex, ey);
            if (spr) begin
                spr_count++;
            end
            if (ex == DISP_WIDTH - 1) begin              // Raster order with wraps
                ex = 0;
                ey = (ey == DISP_HEIGHT - 1) ? 0 : ey + 1;
            end else begin
                ex++;
            end
        end
        if (spr_count == 0) begin
            other_errors++;
            $display("No sprite pixels were expected anywhere in %s", tag);
        end
        $display("%s: %0d sprite pixels compared", tag, spr_count);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        bit found;
        reset      = 1'b1;
        host_we    = 1'b0;
        host_sel   = SEL_PALETTE;
        host_addr  = '0;
        host_wdata = '0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            m_oam[s] = '0;                               // OAM clears on reset
        end
        repeat (3) begin
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b0;
        @(negedge clk);                                  // First pixel out of reset
        check_valid(pixel_valid, 1'b1);
        check_coord(pixel_x, pixel_y, '0, '0);
        load_memory();
        wait_frame_start(found);
        if (found) begin
            check_frame("first frame");
            change_scene();
            wait_frame_start(found);
            if (found) begin
                check_frame("frame after changes");
            end
        end
        $display("Errors: coordinate %0d, colour %0d, other %0d",
                 coord_errors, color_errors, other_errors);
        if (coord_errors + color_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== design/ppu_top.sv ====
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Host memory load port
    input  logic        host_we,
    input  host_sel_t   host_sel,
    input  tile_addr_t  host_addr,
    input  logic [31:0] host_wdata,

    // Video out
    output logic        pixel_valid,
    output xcoord_t     pixel_x,
    output ycoord_t     pixel_y,
    output channel_t    pixel_r,
    output channel_t    pixel_g,
    output channel_t    pixel_b
);

    xcoord_t    raster_x;                                // Shared raster position
    ycoord_t    raster_y;
    pixel_idx_t bg_idx;
    logic       spr_hit;
    logic [2:0] spr_palette;
    pixel_idx_t spr_idx;

    bg_fetch_if     bg_fetch ();
    sprite_fetch_if spr_fetch ();
    color_lookup_if color_lookup ();

    // ========================================================================
    // Memory and the two layer renderers
    // ========================================================================
    video_memory u_video_memory (
        .clk        (clk),
        .reset      (reset),
        .host_we    (host_we),
        .host_sel   (host_sel),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .bg         (bg_fetch.memory),
        .spr        (spr_fetch.memory),
        .pal        (color_lookup.memory)
    );

    background_renderer u_background_renderer (
        .raster_x (raster_x),
        .raster_y (raster_y),
        .fetch    (bg_fetch.renderer),
        .bg_idx   (bg_idx)
    );

    sprite_renderer u_sprite_renderer (
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .fetch       (spr_fetch.renderer),
        .spr_hit     (spr_hit),
        .spr_palette (spr_palette),
        .spr_idx     (spr_idx)
    );

    // Raster timing, mixing and output registers
    scanout u_scanout (
        .clk         (clk),
        .reset       (reset),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .bg_idx      (bg_idx),
        .spr_hit     (spr_hit),
        .spr_palette (spr_palette),
        .spr_idx     (spr_idx),
        .lookup      (color_lookup.mixer),
        .pixel_valid (pixel_valid),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_r     (pixel_r),
        .pixel_g     (pixel_g),
        .pixel_b     (pixel_b)
    );

endmodule

// ==== design/scanout.sv ====
`timescale 1ns/1ps

module scanout import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output xcoord_t    raster_x,                         // Position being rendered
    output ycoord_t    raster_y,
    input  pixel_idx_t bg_idx,
    input  logic       spr_hit,
    input  logic [2:0] spr_palette,
    input  pixel_idx_t spr_idx,
    color_lookup_if.mixer lookup,
    output logic       pixel_valid,
    output xcoord_t    pixel_x,                          // Position of registered colour
    output ycoord_t    pixel_y,
    output channel_t   pixel_r,
    output channel_t   pixel_g,
    output channel_t   pixel_b
);

    color12_t pick;                                      // Winning 12-bit colour
    logic     use_sky;
    channel_t mix_r;
    channel_t mix_g;
    channel_t mix_b;

    // Nibble doubling to 8 bits
    function automatic channel_t widen(input logic [3:0] n);
        return {n, n};
    endfunction

    // ========================================================================
    // Raster counter
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (raster_x == xcoord_t'(DISP_WIDTH - 1)) begin
            raster_x <= '0;                              // End of line
            raster_y <= (raster_y == ycoord_t'(DISP_HEIGHT - 1)) ? '0 : raster_y + 1'b1;
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    // ========================================================================
    // Layer mixing
    // ========================================================================
    assign lookup.bg_addr  = {3'b000, bg_idx};           // Background palette fixed at 0
    assign lookup.spr_addr = {spr_palette, spr_idx};

    assign use_sky = !spr_hit && (bg_idx == TRANSPARENT_BG);
    assign pick    = spr_hit ? lookup.spr_color : lookup.bg_color;

    assign mix_r = use_sky ? SKY_R : widen(pick[11:8]);
    assign mix_g = use_sky ? SKY_G : widen(pick[7:4]);
    assign mix_b = use_sky ? SKY_B : widen(pick[3:0]);

    // Colour and position leave together one clock later
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_valid <= 1'b0;
            pixel_x     <= '0;
            pixel_y     <= '0;
            pixel_r     <= '0;
            pixel_g     <= '0;
            pixel_b     <= '0;
        end else begin
            pixel_valid <= 1'b1;                         // No blanking in this raster
            pixel_x     <= raster_x;
            pixel_y     <= raster_y;
            pixel_r     <= mix_r;
            pixel_g     <= mix_g;
            pixel_b     <= mix_b;
        end
    end

    a_x_visible: assert property (@(posedge clk) disable iff (reset)
        pixel_x < xcoord_t'(DISP_WIDTH))
        else $error("pixel_x %0d beyond visible width", pixel_x);

endmodule

// ==== design/render/sprite_renderer.sv ====
`timescale 1ns/1ps

module sprite_renderer import ppu_pkg::*; (
    input  xcoord_t    raster_x,
    input  ycoord_t    raster_y,
    sprite_fetch_if.renderer fetch,
    output logic       spr_hit,                          // Some opaque sprite covers pixel
    output logic [2:0] spr_palette,
    output pixel_idx_t spr_idx
);

    logic [NUM_SPRITES-1:0] opaque;                      // Covering and not see-through
    pixel_idx_t             sprite_nib [NUM_SPRITES];
    logic [2:0]             sprite_pal [NUM_SPRITES];

    // ========================================================================
    // Per-sprite bounds, flip and pattern fetch
    // ========================================================================
    for (genvar i = 0; i < NUM_SPRITES; i++) begin : gen_sprite
        oam_attr_t  attr;
        xcoord_t    dx;                                  // Offset from left edge
        ycoord_t    dy;                                  // Offset from top edge
        logic       in_box;
        logic [2:0] loc_x;
        logic [2:0] loc_y;

        assign attr = fetch.oam[i].attr;
        assign dx   = raster_x - attr.x;
        assign dy   = raster_y - attr.y;

        // No wrap past the right or bottom edge
        assign in_box = attr.enable
                     && (raster_x >= attr.x) && (dx < xcoord_t'(TILE_DIM))
                     && (raster_y >= attr.y) && (dy < ycoord_t'(TILE_DIM));

        assign loc_x = dx[2:0] ^ {3{attr.hflip}};        // 7 - x when mirrored
        assign loc_y = dy[2:0] ^ {3{attr.vflip}};        // 7 - y when flipped

        assign fetch.tile_addr[i] = {attr.tile, loc_y, loc_x[2:1]};

        assign sprite_nib[i] = loc_x[0] ? fetch.tile_data[i][3:0]
                                        : fetch.tile_data[i][7:4];
        assign sprite_pal[i] = attr.palette;
        assign opaque[i]     = in_box && (sprite_nib[i] != TRANSPARENT_SPRITE);
    end

    // ========================================================================
    // Priority select
    // ========================================================================
    always_comb begin
        spr_hit     = 1'b0;
        spr_palette = '0;
        spr_idx     = TRANSPARENT_SPRITE;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (opaque[i]) begin                         // Later sprite overrides earlier
                spr_hit     = 1'b1;
                spr_palette = sprite_pal[i];
                spr_idx     = sprite_nib[i];
            end
        end
    end

    // A hit must never carry the see-through code to the mixer
    a_hit_opaque: assert property (@(raster_x)
        spr_hit |-> (spr_idx != TRANSPARENT_SPRITE))
        else $error("sprite hit with transparent nibble at x=%0d y=%0d", raster_x, raster_y);

endmodule

// ==== design/render/background_renderer.sv ====
`timescale 1ns/1ps

module background_renderer import ppu_pkg::*; (
    input  xcoord_t    raster_x,
    input  ycoord_t    raster_y,
    bg_fetch_if.renderer fetch,
    output pixel_idx_t bg_idx                            // 0 means sky
);

    logic [5:0] tile_col;                                // Map column 0..39 on screen
    logic [5:0] tile_row;                                // Map row 0..29 on screen
    logic [2:0] pix_col;                                 // Pixel within tile
    logic [2:0] pix_row;                                 // Line within tile

    assign tile_col = raster_x[8:3];
    assign tile_row = {1'b0, raster_y[7:3]};
    assign pix_col  = raster_x[2:0];
    assign pix_row  = raster_y[2:0];

    // Map lookup
    assign fetch.map_addr = {tile_row, tile_col};

    // 4 bytes per tile line, 2 pixels per byte
    assign fetch.tile_addr = {1'b0, fetch.map_data, pix_row, pix_col[2:1]};

    // Even pixel in high nibble
    assign bg_idx = pix_col[0] ? fetch.tile_data[3:0] : fetch.tile_data[7:4];

endmodule

// ==== design/vram/video_memory.sv ====
`timescale 1ns/1ps

module video_memory import ppu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      host_we,                           // One-cycle write strobe
    input  host_sel_t host_sel,
    input  tile_addr_t host_addr,
    input  logic [31:0] host_wdata,
    bg_fetch_if.memory     bg,
    sprite_fetch_if.memory spr,
    color_lookup_if.memory pal
);

    color12_t   palette_mem [PAL_ENTRIES];               // 8 palettes x 16 colours
    logic [7:0] tile_mem    [TILE_MEM_BYTES];            // Pattern bytes, high nibble first
    logic [7:0] map_mem     [MAP_ENTRIES];               // Tile numbers, row major
    oam_entry_u oam_mem     [NUM_SPRITES];

    logic [14:0] sel_depth;                              // Entries in selected array

    // ========================================================================
    // Host writes
    // ========================================================================
    always_ff @(posedge clk) begin
        if (host_we) begin
            case (host_sel)
                SEL_PALETTE: palette_mem[pal_addr_t'(host_addr)] <= host_wdata[11:0];
                SEL_TILE:    tile_mem[host_addr]                 <= host_wdata[7:0];
                SEL_MAP:     map_mem[map_addr_t'(host_addr)]     <= host_wdata[7:0];
                default: ;                               // OAM handled below
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                oam_mem[i] <= '0;                        // All sprites off
            end
        end else if (host_we && host_sel == SEL_OAM) begin
            oam_mem[oam_addr_t'(host_addr)].raw <= host_wdata; // Whole attribute word
        end
    end

    // ========================================================================
    // Asynchronous read ports
    // ========================================================================
    assign bg.map_data  = map_mem[bg.map_addr];
    assign bg.tile_data = tile_mem[bg.tile_addr];

    assign pal.bg_color  = palette_mem[pal.bg_addr];
    assign pal.spr_color = palette_mem[pal.spr_addr];

    for (genvar i = 0; i < NUM_SPRITES; i++) begin : gen_spr_port
        assign spr.oam[i]       = oam_mem[i];
        assign spr.tile_data[i] = tile_mem[spr.tile_addr[i]]; // Dedicated pattern port
    end

    // Host address must fit the array it targets
    always_comb begin
        case (host_sel)
            SEL_PALETTE: sel_depth = 15'(PAL_ENTRIES);
            SEL_TILE:    sel_depth = 15'(TILE_MEM_BYTES);
            SEL_MAP:     sel_depth = 15'(MAP_ENTRIES);
            default:     sel_depth = 15'(NUM_SPRITES);
        endcase
    end

    a_host_addr_range: assert property (@(posedge clk) disable iff (reset)
        host_we |-> ({1'b0, host_addr} < sel_depth))
        else $error("host write address %0h out of range for select %0d", host_addr, host_sel);

endmodule

// ==== common/ppu_if.sv ====
`timescale 1ns/1ps

// Background map and pattern fetch
interface bg_fetch_if import ppu_pkg::*; ();
    map_addr_t  map_addr;                                // From renderer
    tile_addr_t tile_addr;                               // From renderer
    logic [7:0] map_data;                                // Tile number at map_addr
    logic [7:0] tile_data;                               // Two pixels at tile_addr

    modport memory   (input  map_addr, tile_addr, output map_data, tile_data);
    modport renderer (output map_addr, tile_addr, input  map_data, tile_data);
endinterface

// Per-sprite attribute and pattern fetch
interface sprite_fetch_if import ppu_pkg::*; ();
    oam_entry_u oam       [NUM_SPRITES];                 // Live OAM contents
    tile_addr_t tile_addr [NUM_SPRITES];                 // One pattern port per sprite
    logic [7:0] tile_data [NUM_SPRITES];

    modport memory   (output oam, tile_data, input  tile_addr);
    modport renderer (input  oam, tile_data, output tile_addr);
endinterface

// Palette lookups for both layers
interface color_lookup_if import ppu_pkg::*; ();
    pal_addr_t bg_addr;                                  // Always palette 0
    pal_addr_t spr_addr;
    color12_t  bg_color;
    color12_t  spr_color;

    modport memory (input  bg_addr, spr_addr, output bg_color, spr_color);
    modport mixer  (output bg_addr, spr_addr, input  bg_color, spr_color);
endinterface

// ==== common/ppu_pkg.sv ====
package ppu_pkg;

    // ========================================================================
    // Display and raster
    // ========================================================================
    localparam int DISP_WIDTH  = 320;                    // Visible pixels per line
    localparam int DISP_HEIGHT = 240;                    // Visible lines per frame

    typedef logic [8:0] xcoord_t;                        // 0..319
    typedef logic [7:0] ycoord_t;                        // 0..239

    // ========================================================================
    // Tiles and background map
    // ========================================================================
    localparam int TILE_BYTES     = 32;                  // 8x8 at 4 bpp
    localparam int TILE_DIM       = 8;                   // Tile side in pixels
    localparam int NUM_TILES      = 512;
    localparam int TILE_MEM_BYTES = NUM_TILES * TILE_BYTES; // 16 KB of pattern data
    localparam int MAP_DIM        = 64;                  // 64x64 tile map
    localparam int MAP_ENTRIES    = MAP_DIM * MAP_DIM;

    typedef logic [13:0] tile_addr_t;                    // Byte address into pattern data
    typedef logic [11:0] map_addr_t;                     // {row, column}
    typedef logic [3:0]  pixel_idx_t;                    // One 4 bpp nibble

    localparam pixel_idx_t TRANSPARENT_SPRITE = 4'hF;    // Sprite see-through code
    localparam pixel_idx_t TRANSPARENT_BG     = 4'h0;    // Background shows sky

    // ========================================================================
    // Palettes and colour
    // ========================================================================
    localparam int NUM_PALETTES = 8;
    localparam int PALETTE_SIZE = 16;
    localparam int PAL_ENTRIES  = NUM_PALETTES * PALETTE_SIZE;

    typedef logic [6:0]  pal_addr_t;                     // {palette, entry}
    typedef logic [11:0] color12_t;                      // 4:4:4 RGB
    typedef logic [7:0]  channel_t;                      // Output channel

    localparam channel_t SKY_R = 8'h88;
    localparam channel_t SKY_G = 8'hDD;
    localparam channel_t SKY_B = 8'hFF;

    // ========================================================================
    // Sprite attribute memory
    // ========================================================================
    localparam int NUM_SPRITES = 8;

    typedef logic [2:0] oam_addr_t;

    typedef struct packed {
        logic       enable;
        logic       vflip;
        logic       hflip;
        logic [2:0] palette;
        logic [8:0] tile;
        ycoord_t    y;                                   // Top edge
        xcoord_t    x;                                   // Left edge
    } oam_attr_t;

    typedef union packed {
        logic [31:0] raw;                                // Host view
        oam_attr_t   attr;                               // Renderer view
    } oam_entry_u;

    // Host write target
    typedef enum logic [1:0] {
        SEL_PALETTE = 2'd0,
        SEL_TILE    = 2'd1,
        SEL_MAP     = 2'd2,
        SEL_OAM     = 2'd3
    } host_sel_t;

endpackage
